// ==== include/vid_defines.svh ====
// Project-wide widths, OSD colour levels and pipeline depth for the video path
// Include in any file that needs a width or level and not just a package type

`ifndef VID_DEFINES_SVH
`define VID_DEFINES_SVH

////////////////////////////////////////////////////////////
// Channel widths
////////////////////////////////////////////////////////////
`define VID_CHAN_W 8          // Chipset colour channel
`define VGA_WIDTH 6           // Colour bits per channel at the VGA pins

////////////////////////////////////////////////////////////
// On-screen display colour levels
////////////////////////////////////////////////////////////
`define OSD_LEVEL_W 2
`define OSD_ON_LEVEL 2'd3         // Pixel set, all channels
`define OSD_OFF_LEVEL 2'd0        // Background red and green
`define OSD_OFF_BLUE_LEVEL 2'd2   // Background blue gives the blue tint

// Input sample to VGA pins, in clk_vid cycles
`define VID_PIPE_DEPTH 3

`endif

// ==== design/vid_pkg.sv ====
// Width types shared along the video output path
// Modules and the pixel interface reach these through vid_pkg:: names

`include "vid_defines.svh"

package vid_pkg;

  ////////////////////////////////////////////////////////////
  // Colour types
  ////////////////////////////////////////////////////////////

  // Full chipset colour channel
  typedef logic [`VID_CHAN_W-1:0] chan_t;

  // Truncated channel as driven onto the VGA DAC
  typedef logic [`VGA_WIDTH-1:0] vga_chan_t;

  // OSD level that replaces the top bits of a channel
  typedef logic [`OSD_LEVEL_W-1:0] osd_level_t;

endpackage

// ==== design/vid_pixel_if.sv ====
// One pixel with its syncs between two stages of the video pipeline
// Valid on every clk_vid cycle, there is no handshake

`timescale 1ns/1ps

interface vid_pixel_if;

  vid_pkg::chan_t red;
  vid_pkg::chan_t green;
  vid_pkg::chan_t blue;
  logic hs;           // Active low as received
  logic vs;
  logic cs;           // Composite sync
  logic force_csync;  // Route cs to the VGA hsync pin

  modport source (
    output red, green, blue,
    output hs, vs, cs,
    output force_csync
  );

  modport sink (
    input red, green, blue,
    input hs, vs, cs,
    input force_csync
  );

endinterface

// ==== design/vid_sync_decode.sv ====
// Input capture of the chipset pixel stream in the clk_vid domain
// Registers colour, syncs and OSD bits and decodes the forced composite sync

`timescale 1ns/1ps

module vid_sync_decode (
  input  logic           clk_vid,
  input  logic           rst,
  input  vid_pkg::chan_t red,
  input  vid_pkg::chan_t green,
  input  vid_pkg::chan_t blue,
  input  logic           hs,
  input  logic           vs,
  input  logic           cs,
  input  logic           osd_window,
  input  logic           osd_pixel,
  input  logic           selcsync,    // Chipset asks for composite sync
  input  logic           ypbpr,       // Component output needs csync
  input  logic           no_csync,    // User override of selcsync
  vid_pixel_if.source    cap,
  output logic           osd_window_q,
  output logic           osd_pixel_q
);

  logic force_csync;

  // YPbPr always wants csync, otherwise follow the chipset unless vetoed
  assign force_csync = ypbpr | (selcsync & ~no_csync);

  ////////////////////////////////////////////////////////////
  // Capture register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_vid) begin
    if (rst) begin
      cap.red         <= '0;
      cap.green       <= '0;
      cap.blue        <= '0;
      cap.hs          <= 1'b0;
      cap.vs          <= 1'b0;
      cap.cs          <= 1'b0;
      cap.force_csync <= 1'b0;
      osd_window_q    <= 1'b0;
      osd_pixel_q     <= 1'b0;
    end else begin
      cap.red         <= red;
      cap.green       <= green;
      cap.blue        <= blue;
      cap.hs          <= hs;
      cap.vs          <= vs;
      cap.cs          <= cs;
      cap.force_csync <= force_csync;
      osd_window_q    <= osd_window;  // Kept in step with the pixel
      osd_pixel_q     <= osd_pixel;
    end
  end

  // YPbPr mode must show up as forced csync one cycle later
  a_ypbpr_forces_csync : assert property (
    @(posedge clk_vid) disable iff (rst)
    ypbpr |=> cap.force_csync
  );

endmodule

// ==== design/osd_overlay.sv ====
// OSD overlay stage between capture and the VGA output stage
// Inside the OSD window the top two bits of each channel carry the OSD level

`timescale 1ns/1ps

`include "vid_defines.svh"

module osd_overlay (
  input  logic        clk_vid,
  input  logic        rst,
  vid_pixel_if.sink   src,
  input  logic        osd_window,
  input  logic        osd_pixel,
  vid_pixel_if.source dst
);

  vid_pkg::osd_level_t level_rg;
  vid_pkg::osd_level_t level_b;
  vid_pkg::chan_t      red_mix;
  vid_pkg::chan_t      green_mix;
  vid_pkg::chan_t      blue_mix;

  // Level on top, picture shifted down underneath
  function automatic vid_pkg::chan_t osd_mix(
    input vid_pkg::osd_level_t level,
    input vid_pkg::chan_t      pix
  );
    osd_mix = {level, pix[`VID_CHAN_W-1 -: `VID_CHAN_W-`OSD_LEVEL_W]};
  endfunction

  always_comb begin
    level_rg = osd_pixel ? `OSD_ON_LEVEL : `OSD_OFF_LEVEL;
    level_b  = osd_pixel ? `OSD_ON_LEVEL : `OSD_OFF_BLUE_LEVEL;
    if (osd_window) begin
      red_mix   = osd_mix(level_rg, src.red);
      green_mix = osd_mix(level_rg, src.green);
      blue_mix  = osd_mix(level_b, src.blue);
    end else begin
      red_mix   = src.red;    // Outside the window
      green_mix = src.green;
      blue_mix  = src.blue;
    end
  end

  always_ff @(posedge clk_vid) begin
    if (rst) begin
      dst.red         <= '0;
      dst.green       <= '0;
      dst.blue        <= '0;
      dst.hs          <= 1'b0;
      dst.vs          <= 1'b0;
      dst.cs          <= 1'b0;
      dst.force_csync <= 1'b0;
    end else begin
      dst.red         <= red_mix;
      dst.green       <= green_mix;
      dst.blue        <= blue_mix;
      dst.hs          <= src.hs;          // Syncs follow the pixel
      dst.vs          <= src.vs;
      dst.cs          <= src.cs;
      dst.force_csync <= src.force_csync;
    end
  end

  // Closed window means the colour only gains one cycle of delay
  a_window_clear_passes : assert property (
    @(posedge clk_vid) disable iff (rst)
    !osd_window |=> (dst.red == $past(src.red))
  );

endmodule

// ==== design/vga_out_stage.sv ====
// Final VGA register stage with sync polarity and composite sync selection
// Colours are cut down to the VGA pin width here

`timescale 1ns/1ps

`include "vid_defines.svh"

module vga_out_stage (
  input  logic               clk_vid,
  input  logic               rst,
  vid_pixel_if.sink          src,
  input  logic               hsyncpol,  // Quasi-static, read unregistered
  input  logic               vsyncpol,
  output logic               vga_hs,
  output logic               vga_vs,
  output vid_pkg::vga_chan_t vga_r,
  output vid_pkg::vga_chan_t vga_g,
  output vid_pkg::vga_chan_t vga_b
);

  logic hs_next;
  logic vs_next;
  logic [$clog2(`VID_PIPE_DEPTH+1)-1:0] settle_cnt;

  ////////////////////////////////////////////////////////////
  // Sync selection
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (src.force_csync) begin
      hs_next = src.cs;       // Csync goes out on the hsync pin
      vs_next = 1'b1;
    end else begin
      hs_next = src.hs ^ hsyncpol;
      vs_next = src.vs ^ vsyncpol;
    end
  end

  always_ff @(posedge clk_vid) begin
    if (rst) begin
      vga_hs <= 1'b0;
      vga_vs <= 1'b0;
      vga_r  <= '0;
      vga_g  <= '0;
      vga_b  <= '0;
    end else begin
      vga_hs <= hs_next;
      vga_vs <= vs_next;
      vga_r  <= src.red[`VID_CHAN_W-1 -: `VGA_WIDTH];    // Keep the MSBs
      vga_g  <= src.green[`VID_CHAN_W-1 -: `VGA_WIDTH];
      vga_b  <= src.blue[`VID_CHAN_W-1 -: `VGA_WIDTH];
    end
  end

  ////////////////////////////////////////////////////////////
  // Pipeline fill tracking
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_vid) begin
    if (rst) begin
      settle_cnt <= '0;
    end else if (settle_cnt != `VID_PIPE_DEPTH) begin
      settle_cnt <= settle_cnt + 1'b1;  // Saturates once the pipe is full
    end
  end

  // Whole pipeline filled from the inputs, so nothing may be X
  a_outputs_known : assert property (
    @(posedge clk_vid) disable iff (rst)
    (settle_cnt == `VID_PIPE_DEPTH) |-> !$isunknown({vga_hs, vga_vs, vga_r, vga_g, vga_b})
  );

endmodule

// ==== design/vid_out_top.sv ====
// Top of the clk_vid video output path from chipset pixels to VGA pins
// Capture, OSD overlay and output stage give three cycles of latency

`timescale 1ns/1ps

module vid_out_top (
  input  logic               clk_vid,
  input  logic               rst,
  input  vid_pkg::chan_t     red,
  input  vid_pkg::chan_t     green,
  input  vid_pkg::chan_t     blue,
  input  logic               hs,
  input  logic               vs,
  input  logic               cs,
  input  logic               osd_window,
  input  logic               osd_pixel,
  input  logic               selcsync,
  input  logic               ypbpr,
  input  logic               no_csync,
  input  logic               hsyncpol,
  input  logic               vsyncpol,
  output logic               vga_hs,
  output logic               vga_vs,
  output vid_pkg::vga_chan_t vga_r,
  output vid_pkg::vga_chan_t vga_g,
  output vid_pkg::vga_chan_t vga_b
);

  logic osd_window_q;
  logic osd_pixel_q;

  vid_pixel_if cap_bus ();  // Capture to overlay
  vid_pixel_if mix_bus ();  // Overlay to output

  vid_sync_decode i_decode (
    .clk_vid      (clk_vid),
    .rst          (rst),
    .red          (red),
    .green        (green),
    .blue         (blue),
    .hs           (hs),
    .vs           (vs),
    .cs           (cs),
    .osd_window   (osd_window),
    .osd_pixel    (osd_pixel),
    .selcsync     (selcsync),
    .ypbpr        (ypbpr),
    .no_csync     (no_csync),
    .cap          (cap_bus),
    .osd_window_q (osd_window_q),
    .osd_pixel_q  (osd_pixel_q)
  );

  osd_overlay i_overlay (
    .clk_vid    (clk_vid),
    .rst        (rst),
    .src        (cap_bus),
    .osd_window (osd_window_q),
    .osd_pixel  (osd_pixel_q),
    .dst        (mix_bus)
  );

  vga_out_stage i_out (
    .clk_vid  (clk_vid),
    .rst      (rst),
    .src      (mix_bus),
    .hsyncpol (hsyncpol),
    .vsyncpol (vsyncpol),
    .vga_hs   (vga_hs),
    .vga_vs   (vga_vs),
    .vga_r    (vga_r),
    .vga_g    (vga_g),
    .vga_b    (vga_b)
  );

endmodule

// ==== sim/tb_clock_gen.sv ====
// Clock and reset for the video path testbench
// clk_vid runs at 40 ns, rst is held high for the first 4 rising edges

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_vid,
  output logic rst
);

  initial begin
    clk_vid = 1'b0;
    forever #20 clk_vid = ~clk_vid;  // 40 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk_vid);
    #1 rst = 1'b0;  // Released just after the 4th edge
  end

endmodule

// ==== sim/tb_vid_out.sv ====
// Testbench for the clk_vid video output path
// Drives random and directed pixels, predicts the VGA pins and checks them

`timescale 1ns/1ps

`include "vid_defines.svh"

module tb_vid_out;

  localparam int OUT_W = 2 + 3 * `VGA_WIDTH;  // {hs, vs, r, g, b}
  localparam int IDLE_N = 64;
  localparam int PASS_N = 500;
  localparam int OSD_N = 500;
  localparam int POL_N = 100;    // Per polarity combination
  localparam int CSYNC_N = 100;  // Per csync mode
  localparam int LAT_N = 36;
  localparam int TEST_CYCLES = IDLE_N + PASS_N + OSD_N + 4 * POL_N + 5 * CSYNC_N + LAT_N;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + TEST_CYCLES / 2;
  // Modes as {ypbpr, selcsync, no_csync}
  localparam logic [14:0] CSYNC_MODES = {3'b100, 3'b101, 3'b010, 3'b011, 3'b110};

  typedef struct packed {
    vid_pkg::chan_t red;
    vid_pkg::chan_t green;
    vid_pkg::chan_t blue;
    logic hs, vs, cs, osd_window, osd_pixel, selcsync, ypbpr, no_csync;
  } pix_sample_t;

  logic clk_vid, rst;
  vid_pkg::chan_t red, green, blue;
  logic hs, vs, cs, osd_window, osd_pixel, selcsync, ypbpr, no_csync;
  logic hsyncpol, vsyncpol;
  logic vga_hs, vga_vs;
  vid_pkg::vga_chan_t vga_r, vga_g, vga_b;

  int          cycle;
  logic [31:0] rng_state;
  pix_sample_t sample_q[$];  // Expected pipeline contents
  int          stamp_q[$];   // Cycle each sample was driven
  string       name_q[$];
  bit          pipe_started;

  tb_clock_gen i_clk_gen (.clk_vid(clk_vid), .rst(rst));

  vid_out_top i_dut (.*);

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // VGA pins for one sample under the given polarity levels
  function automatic logic [OUT_W-1:0] expected_output(input pix_sample_t s,
                                                       input logic hpol, input logic vpol);
    vid_pkg::osd_level_t lvl_rg;
    vid_pkg::osd_level_t lvl_b;
    vid_pkg::chan_t r;
    vid_pkg::chan_t g;
    vid_pkg::chan_t b;
    logic csync_on;
    csync_on = s.ypbpr | (s.selcsync & ~s.no_csync);
    lvl_rg = s.osd_pixel ? `OSD_ON_LEVEL : `OSD_OFF_LEVEL;
    lvl_b = s.osd_pixel ? `OSD_ON_LEVEL : `OSD_OFF_BLUE_LEVEL;
    r = s.red;
    g = s.green;
    b = s.blue;
    if (s.osd_window) begin  // Level on top, picture moved down
      r = {lvl_rg, s.red[`VID_CHAN_W-1:`OSD_LEVEL_W]};
      g = {lvl_rg, s.green[`VID_CHAN_W-1:`OSD_LEVEL_W]};
      b = {lvl_b, s.blue[`VID_CHAN_W-1:`OSD_LEVEL_W]};
    end
    return {(csync_on ? s.cs : (s.hs ^ hpol)), (csync_on ? 1'b1 : (s.vs ^ vpol)),
            r[`VID_CHAN_W-1:`VID_CHAN_W-`VGA_WIDTH], g[`VID_CHAN_W-1:`VID_CHAN_W-`VGA_WIDTH],
            b[`VID_CHAN_W-1:`VID_CHAN_W-`VGA_WIDTH]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "Output mismatch in %s", name);
    end
  endtask

  // One pixel per cycle, 2 ns after the edge
  task automatic drive_sample(input pix_sample_t s, input string name);
    @(posedge clk_vid);
    #2;
    {red, green, blue, hs, vs, cs, osd_window, osd_pixel, selcsync, ypbpr, no_csync} = s;
    sample_q.push_back(s);
    stamp_q.push_back(cycle);
    name_q.push_back(name);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////////////////////////
  task automatic pixels_through(input int count, input bit window, input string name);
    pix_sample_t s;
    repeat (count) begin
      s = pix_sample_t'(next_random());
      s.osd_window = window;
      s.ypbpr = 1'b0;
      s.selcsync = 1'b0;  // Plain VGA syncs
      drive_sample(s, name);
    end
  endtask

  task automatic sweep_polarity();
    for (int p = 0; p < 4; p++) begin
      {hsyncpol, vsyncpol} = 2'(p);
      pixels_through(POL_N, 1'b0, $sformatf("polarity %0d", p));
    end
  endtask

  task automatic force_csync_cases();
    pix_sample_t s;
    logic [31:0] r;
    logic [2:0]  mode;
    for (int i = 0; i < 5; i++) begin
      mode = CSYNC_MODES[3*i +: 3];
      r = next_random();
      {hsyncpol, vsyncpol} = r[1:0];
      repeat (CSYNC_N) begin
        s = pix_sample_t'(next_random());
        {s.ypbpr, s.selcsync, s.no_csync} = mode;
        drive_sample(s, $sformatf("csync mode %03b", mode));
      end
    end
  endtask

  // Single bright pixel in a flat field, counted from drive to pins
  task automatic measure_latency();
    pix_sample_t quiet;
    pix_sample_t marked;
    int mark_cycle;
    int seen;
    bit found;
    quiet = '0;
    quiet.red = 8'h14;
    quiet.green = 8'h28;
    quiet.blue = 8'h3c;
    {quiet.hs, quiet.vs, quiet.cs} = 3'b111;
    marked = quiet;
    marked.red = 8'hd0;
    {hsyncpol, vsyncpol} = 2'b00;
    repeat (8) drive_sample(quiet, "latency");
    drive_sample(marked, "latency");
    mark_cycle = cycle;
    found = 1'b0;
    seen = 0;
    for (int i = 0; i < 16 && !found; i++) begin
      drive_sample(quiet, "latency");
      if (vga_r == marked.red[`VID_CHAN_W-1 -: `VGA_WIDTH]) begin
        found = 1'b1;
        seen = cycle - mark_cycle;
      end
    end
    if (!found) begin
      $display("*** FAILED ***");
      $fatal(1, "The marked pixel never reached the VGA outputs");
    end else begin
      check_value("latency", 32'(`VID_PIPE_DEPTH), 32'(seen));
      repeat (4) drive_sample(quiet, "latency");
    end
  endtask

  initial begin : stimulus
    // Busy inputs while in reset, the pins must still stay at zero
    {red, green, blue} = {8'ha5, 8'h5a, 8'hc3};
    {hs, vs, cs} = 3'b111;
    {osd_window, osd_pixel, selcsync, ypbpr, no_csync} = 5'b11100;
    {hsyncpol, vsyncpol} = 2'b00;
    rng_state = 32'h66c5ecd6;
    wait (rst === 1'b0);
    #1;
    {red, green, blue, hs, vs, cs} = '0;
    {osd_window, osd_pixel, selcsync, ypbpr, no_csync} = '0;
    repeat (IDLE_N) drive_sample('0, "idle");
    pixels_through(PASS_N, 1'b0, "pass-through");
    pixels_through(OSD_N, 1'b1, "osd overlay");
    sweep_polarity();
    force_csync_cases();
    measure_latency();
    while (stamp_q.size() != 0) @(posedge clk_vid);  // Let the pipeline drain
    $display("*** PASSED ***");
    $finish;
  end

  // Compares the pins 1 ns after each edge
  initial begin : compare_outputs
    pix_sample_t s;
    string name;
    logic [OUT_W-1:0] exp_pins;
    logic [OUT_W-1:0] act_pins;
    pipe_started = 1'b0;
    forever begin
      @(posedge clk_vid);
      #1;
      act_pins = {vga_hs, vga_vs, vga_r, vga_g, vga_b};
      if (stamp_q.size() != 0 && stamp_q[0] + `VID_PIPE_DEPTH == cycle) begin
        s = sample_q.pop_front();
        void'(stamp_q.pop_front());
        name = name_q.pop_front();
        exp_pins = expected_output(s, hsyncpol, vsyncpol);
        pipe_started = 1'b1;
        check_value({name, " sync"}, 32'(exp_pins[OUT_W-1 -: 2]), 32'(act_pins[OUT_W-1 -: 2]));
        check_value({name, " colour"}, 32'(exp_pins[OUT_W-3:0]), 32'(act_pins[OUT_W-3:0]));
      end else if (!pipe_started) begin
        check_value("reset", 32'(0), 32'(act_pins));  // Reset values still in the pipe
      end
    end
  end

  initial begin : watchdog
    cycle = 0;
    while (cycle < TIMEOUT_CYCLES) begin
      @(posedge clk_vid);
      cycle = cycle + 1;
    end
    $display("*** FAILED ***");
    $fatal(1, "Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
  end

endmodule

// ==== flist.f ====
+incdir+include
design/vid_pkg.sv
design/vid_pixel_if.sv
design/vid_sync_decode.sv
design/osd_overlay.sv
design/vga_out_stage.sv
design/vid_out_top.sv
sim/tb_clock_gen.sv
sim/tb_vid_out.sv

// ==== Makefile ====
# Verilator build and run for the video output path testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_vid_out
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
